// ==== include/cc_consts.svh ====
// Core complex constants
// Widths, port counts and queue depth shared by the package and the RTL

`ifndef CC_CONSTS_SVH
`define CC_CONSTS_SVH

// Data path
`define CC_ADDR_W 32
`define CC_DATA_W 32

// Offload register tag and target select
`define CC_ID_W  5
`define CC_TGT_W 2

// Number of external accelerator ports
`define CC_NUM_ACC 3

// log2 of the TCDM size, sets the NAPOT match mask
`define CC_TCDM_ADDR_W 12

// Outstanding data requests tracked by the order queue
`define CC_ORDER_DEPTH 4

`endif

// ==== source/cc_pkg.sv ====
// Core complex types
// Offload and data request/response payloads and the data port select

`default_nettype none

`include "cc_consts.svh"

package cc_pkg;

  // Offload request from the core, target picks the accelerator port
  typedef struct packed {
    logic [`CC_ID_W-1:0]  id;
    logic [`CC_TGT_W-1:0] target;
    logic [31:0]          op;
    logic [31:0]          arg;
  } acc_req_t;

  // Offload response, id echoes the request tag
  typedef struct packed {
    logic [`CC_ID_W-1:0] id;
    logic [31:0]         data;
    logic                error;
  } acc_rsp_t;

  // Data memory request
  typedef struct packed {
    logic [`CC_ADDR_W-1:0]   addr;
    logic                    write;
    logic [`CC_DATA_W-1:0]   wdata;
    logic [`CC_DATA_W/8-1:0] strb;
  } data_req_t;

  typedef struct packed {
    logic [`CC_DATA_W-1:0] rdata;
  } data_rsp_t;

  // Port chosen for a data request
  typedef enum logic {
    SEL_SOC  = 1'b0,
    SEL_TCDM = 1'b1
  } data_sel_e;

endpackage

`default_nettype wire

// ==== source/acc_if.sv ====
// Offload stream interface
// Valid/ready handshake with a typed payload

`timescale 1ns/1ps
`default_nettype none

interface acc_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t payload;

  // Upstream side of a stream
  modport requester (
    output valid,
    output payload,
    input  ready
  );

  // Downstream side of a stream
  modport accelerator (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== source/spill_reg.sv ====
// Spill register
// Two-entry stream buffer, cuts both the valid and the ready path

`timescale 1ns/1ps
`default_nettype none

module spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  acc_if.accelerator in_i,
  acc_if.requester   out_o
);

  // Stage A takes new items, stage B holds one when the output stalls
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = in_i.valid && in_i.ready;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !out_o.ready;
  assign b_drain = b_full_q && out_o.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= in_i.payload;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Ready comes straight from the fill state
  assign in_i.ready    = !a_full_q || !b_full_q;
  assign out_o.valid   = a_full_q || b_full_q;
  // B always holds the older item
  assign out_o.payload = b_full_q ? b_data_q : a_data_q;

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_o.valid && !out_o.ready |=> out_o.valid && $stable(out_o.payload))
    else $error("spill_reg output changed while stalled");

  a_in_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_i.valid && !in_i.ready |=> in_i.valid && $stable(in_i.payload))
    else $error("spill_reg input item withdrawn while full");

endmodule

`default_nettype wire

// ==== source/offload_router.sv ====
// Offload router
// Steers requests to the accelerator ports by target, answers invalid
// targets with an error and merges all responses round-robin

`timescale 1ns/1ps
`default_nettype none

`include "cc_consts.svh"

module offload_router import cc_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  acc_if.accelerator                     req_i,
  acc_if.requester                       rsp_o,
  output logic     [`CC_NUM_ACC-1:0]     acc_req_valid_o,
  input  logic     [`CC_NUM_ACC-1:0]     acc_req_ready_i,
  output acc_req_t                       acc_req_o,
  input  logic     [`CC_NUM_ACC-1:0]     acc_rsp_valid_i,
  output logic     [`CC_NUM_ACC-1:0]     acc_rsp_ready_o,
  input  acc_rsp_t [`CC_NUM_ACC-1:0]     acc_rsp_i
);

  // Accelerator ports plus the internal error source
  localparam int unsigned NumIn = `CC_NUM_ACC + 1;
  localparam int unsigned PtrW  = $clog2(NumIn);

  logic                      tgt_valid;
  logic                      err_valid;
  logic                      err_ready;
  acc_rsp_t                  err_rsp;
  logic     [NumIn-1:0]      arb_valid;
  logic     [NumIn-1:0]      arb_ready;
  acc_rsp_t [NumIn-1:0]      arb_data;
  logic     [PtrW-1:0]       rr_q, rr_d;
  logic     [PtrW-1:0]       winner;
  logic                      any_valid;

  // ------------------------------------------------------------------
  // Request demux
  // ------------------------------------------------------------------
  assign tgt_valid = req_i.payload.target < `CC_NUM_ACC;
  assign acc_req_o = req_i.payload;

  always_comb begin
    acc_req_valid_o = '0;
    req_i.ready     = 1'b0;
    for (int k = 0; k < `CC_NUM_ACC; k++) begin
      if (req_i.payload.target == k) begin
        acc_req_valid_o[k] = req_i.valid;
        req_i.ready        = acc_req_ready_i[k];
      end
    end
    // No such accelerator, consumed when the error response goes out
    if (!tgt_valid) req_i.ready = err_ready;
  end

  // Error response for a missing target
  assign err_valid     = req_i.valid && !tgt_valid;
  assign err_rsp.id    = req_i.payload.id;
  assign err_rsp.data  = '0;
  assign err_rsp.error = 1'b1;

  // ------------------------------------------------------------------
  // Response arbiter
  // ------------------------------------------------------------------
  // Error source sits at the highest index
  assign arb_valid = {err_valid, acc_rsp_valid_i};
  assign arb_data  = {err_rsp, acc_rsp_i};

  // First valid input at or after the pointer wins
  always_comb begin
    logic [PtrW-1:0] idx;
    winner    = rr_q;
    any_valid = 1'b0;
    for (int i = 0; i < NumIn; i++) begin
      idx = PtrW'((rr_q + i) % NumIn);
      if (!any_valid && arb_valid[idx]) begin
        winner    = idx;
        any_valid = 1'b1;
      end
    end
  end

  always_comb begin
    arb_ready         = '0;
    arb_ready[winner] = any_valid && rsp_o.ready;
  end

  assign acc_rsp_ready_o = arb_ready[`CC_NUM_ACC-1:0];
  assign err_ready       = arb_ready[`CC_NUM_ACC];
  assign rsp_o.valid     = any_valid;
  assign rsp_o.payload   = arb_data[winner];

  // Pointer parks on a stalled winner to keep the output stable,
  // and moves past it once the transfer happens
  always_comb begin
    rr_d = rr_q;
    if (any_valid) begin
      if (rsp_o.ready) begin
        rr_d = (winner == PtrW'(NumIn - 1)) ? '0 : PtrW'(winner + 1'b1);
      end else begin
        rr_d = winner;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  a_acc_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(acc_req_valid_o & ~acc_req_ready_i) |=> $stable(acc_req_valid_o) && $stable(acc_req_o))
    else $error("accelerator request changed while stalled");

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_o.valid && !rsp_o.ready |=> rsp_o.valid && $stable(rsp_o.payload))
    else $error("arbiter switched response while stalled");

endmodule

`default_nettype wire

// ==== source/data_router.sv ====
// Data router
// Sends each core data request to TCDM or SoC by a NAPOT match on the TCDM
// base and returns the responses in request order

`timescale 1ns/1ps
`default_nettype none

`include "cc_consts.svh"

module data_router import cc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`CC_ADDR_W-1:0] tcdm_base_i,
  // Core side
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  data_req_t             req_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output data_rsp_t             rsp_o,
  // SoC port
  output logic                  soc_req_valid_o,
  input  logic                  soc_req_ready_i,
  output data_req_t             soc_req_o,
  input  logic                  soc_rsp_valid_i,
  output logic                  soc_rsp_ready_o,
  input  data_rsp_t             soc_rsp_i,
  // TCDM port
  output logic                  tcdm_req_valid_o,
  input  logic                  tcdm_req_ready_i,
  output data_req_t             tcdm_req_o,
  input  logic                  tcdm_rsp_valid_i,
  output logic                  tcdm_rsp_ready_o,
  input  data_rsp_t             tcdm_rsp_i
);

  localparam logic [`CC_ADDR_W-1:0] TcdmMask = {`CC_ADDR_W{1'b1}} << `CC_TCDM_ADDR_W;
  localparam int unsigned PtrW = $clog2(`CC_ORDER_DEPTH);
  localparam int unsigned CntW = $clog2(`CC_ORDER_DEPTH + 1);

  data_sel_e             req_sel, head_sel;
  data_sel_e             order_q [`CC_ORDER_DEPTH];
  logic      [PtrW-1:0]  wr_ptr_q, rd_ptr_q;
  logic      [CntW-1:0]  count_q;
  logic                  full, empty;
  logic                  push, pop;

  // ------------------------------------------------------------------
  // Address decode and request steering
  // ------------------------------------------------------------------
  // Match on all bits above the TCDM size
  assign req_sel = (((req_i.addr ^ tcdm_base_i) & TcdmMask) == '0) ? SEL_TCDM : SEL_SOC;

  assign soc_req_valid_o  = req_valid_i && !full && (req_sel == SEL_SOC);
  assign tcdm_req_valid_o = req_valid_i && !full && (req_sel == SEL_TCDM);
  assign soc_req_o        = req_i;
  assign tcdm_req_o       = req_i;
  assign req_ready_o      = !full &&
                            ((req_sel == SEL_TCDM) ? tcdm_req_ready_i : soc_req_ready_i);

  // Every request, write included, gets exactly one response
  assign push = req_valid_i && req_ready_o;

  // ------------------------------------------------------------------
  // Order queue
  // ------------------------------------------------------------------
  assign full     = count_q == CntW'(`CC_ORDER_DEPTH);
  assign empty    = count_q == '0;
  assign head_sel = order_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) order_q[wr_ptr_q] <= req_sel;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`CC_ORDER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`CC_ORDER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // Response return
  // ------------------------------------------------------------------
  // Only the port at the head is let through, the other one waits
  assign rsp_valid_o = !empty &&
                       ((head_sel == SEL_TCDM) ? tcdm_rsp_valid_i : soc_rsp_valid_i);
  assign rsp_o       = (head_sel == SEL_TCDM) ? tcdm_rsp_i : soc_rsp_i;

  assign tcdm_rsp_ready_o = !empty && (head_sel == SEL_TCDM) && rsp_ready_i;
  assign soc_rsp_ready_o  = !empty && (head_sel == SEL_SOC) && rsp_ready_i;

  assign pop = rsp_valid_o && rsp_ready_i;

  a_no_orphan_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (soc_rsp_valid_i || tcdm_rsp_valid_i) |-> !empty)
    else $error("data response without an outstanding request");

endmodule

`default_nettype wire

// ==== source/cc_top.sv ====
// Core complex data-movement fabric
// Offload cut registers and router, plus the TCDM/SoC data router

`timescale 1ns/1ps
`default_nettype none

`include "cc_consts.svh"

module cc_top import cc_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic     [`CC_ADDR_W-1:0]     tcdm_base_i,
  // Offload request from the core
  input  logic                          acc_req_valid_i,
  output logic                          acc_req_ready_o,
  input  acc_req_t                      acc_req_i,
  // Offload response to the core
  output logic                          acc_rsp_valid_o,
  input  logic                          acc_rsp_ready_i,
  output acc_rsp_t                      acc_rsp_o,
  // Accelerator ports
  output logic     [`CC_NUM_ACC-1:0]    acc_req_valid_o,
  input  logic     [`CC_NUM_ACC-1:0]    acc_req_ready_i,
  output acc_req_t                      acc_req_o,
  input  logic     [`CC_NUM_ACC-1:0]    acc_rsp_valid_i,
  output logic     [`CC_NUM_ACC-1:0]    acc_rsp_ready_o,
  input  acc_rsp_t [`CC_NUM_ACC-1:0]    acc_rsp_i,
  // Core data port
  input  logic                          data_req_valid_i,
  output logic                          data_req_ready_o,
  input  data_req_t                     data_req_i,
  output logic                          data_rsp_valid_o,
  input  logic                          data_rsp_ready_i,
  output data_rsp_t                     data_rsp_o,
  // SoC port
  output logic                          soc_req_valid_o,
  input  logic                          soc_req_ready_i,
  output data_req_t                     soc_req_o,
  input  logic                          soc_rsp_valid_i,
  output logic                          soc_rsp_ready_o,
  input  data_rsp_t                     soc_rsp_i,
  // TCDM port
  output logic                          tcdm_req_valid_o,
  input  logic                          tcdm_req_ready_i,
  output data_req_t                     tcdm_req_o,
  input  logic                          tcdm_rsp_valid_i,
  output logic                          tcdm_rsp_ready_o,
  input  data_rsp_t                     tcdm_rsp_i
);

  acc_if #(.payload_t(acc_req_t)) core_req ();
  acc_if #(.payload_t(acc_req_t)) acc_req_q ();
  acc_if #(.payload_t(acc_rsp_t)) acc_rsp_q ();
  acc_if #(.payload_t(acc_rsp_t)) core_rsp ();

  // Core offload ports onto the streams
  assign core_req.valid   = acc_req_valid_i;
  assign core_req.payload = acc_req_i;
  assign acc_req_ready_o  = core_req.ready;

  assign acc_rsp_valid_o  = core_rsp.valid;
  assign acc_rsp_o        = core_rsp.payload;
  assign core_rsp.ready   = acc_rsp_ready_i;

  // ------------------------------------------------------------------
  // Offload path
  // ------------------------------------------------------------------
  spill_reg #(
    .T (acc_req_t)
  ) i_spill_req (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in_i   (core_req),
    .out_o  (acc_req_q)
  );

  offload_router i_offload_router (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (acc_req_q),
    .rsp_o           (acc_rsp_q),
    .acc_req_valid_o (acc_req_valid_o),
    .acc_req_ready_i (acc_req_ready_i),
    .acc_req_o       (acc_req_o),
    .acc_rsp_valid_i (acc_rsp_valid_i),
    .acc_rsp_ready_o (acc_rsp_ready_o),
    .acc_rsp_i       (acc_rsp_i)
  );

  spill_reg #(
    .T (acc_rsp_t)
  ) i_spill_rsp (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in_i   (acc_rsp_q),
    .out_o  (core_rsp)
  );

  // ------------------------------------------------------------------
  // Data path
  // ------------------------------------------------------------------
  data_router i_data_router (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tcdm_base_i      (tcdm_base_i),
    .req_valid_i      (data_req_valid_i),
    .req_ready_o      (data_req_ready_o),
    .req_i            (data_req_i),
    .rsp_valid_o      (data_rsp_valid_o),
    .rsp_ready_i      (data_rsp_ready_i),
    .rsp_o            (data_rsp_o),
    .soc_req_valid_o  (soc_req_valid_o),
    .soc_req_ready_i  (soc_req_ready_i),
    .soc_req_o        (soc_req_o),
    .soc_rsp_valid_i  (soc_rsp_valid_i),
    .soc_rsp_ready_o  (soc_rsp_ready_o),
    .soc_rsp_i        (soc_rsp_i),
    .tcdm_req_valid_o (tcdm_req_valid_o),
    .tcdm_req_ready_i (tcdm_req_ready_i),
    .tcdm_req_o       (tcdm_req_o),
    .tcdm_rsp_valid_i (tcdm_rsp_valid_i),
    .tcdm_rsp_ready_o (tcdm_rsp_ready_o),
    .tcdm_rsp_i       (tcdm_rsp_i)
  );

endmodule

`default_nettype wire

// ==== verification/tb_cc.sv ====
// Testbench for the core complex fabric
// Accelerator and memory models, file-driven stimulus and response checks

`timescale 1ns/1ps
`default_nettype none

`include "cc_consts.svh"

// One memory port with in-order responses after a random delay
module mem_port_model import cc_pkg::*; #(
  parameter int unsigned MaxDelay = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  data_req_t req_i,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output data_rsp_t rsp_o
);

  logic [31:0] mem [256];
  logic        written [256];
  logic [31:0] rsp_q [$];
  logic        fired;
  int unsigned wait_cnt;

  initial begin
    req_ready_o = 1'b1;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    fired       = 1'b0;
    wait_cnt    = 0;
    for (int i = 0; i < 256; i++) begin
      written[i] = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    logic [31:0] word;
    logic [7:0]  idx;
    if (rst_ni && req_valid_i && req_ready_o) begin
      idx = req_i.addr[9:2];
      // Unwritten words read a pattern of the full word address
      word = written[idx] ? mem[idx] : ({req_i.addr[31:2], 2'b00} ^ 32'ha5a5_5a5a);
      if (req_i.write) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) word[8*b +: 8] = req_i.wdata[8*b +: 8];
        end
        mem[idx]     = word;
        written[idx] = 1'b1;
        rsp_q.push_back('0);
      end else begin
        rsp_q.push_back(word);
      end
    end
    if (rst_ni && rsp_valid_o && rsp_ready_i) begin
      void'(rsp_q.pop_front());
      fired = 1'b1;
    end
  end

  always @(negedge clk_i) begin
    if (fired) begin
      rsp_valid_o = 1'b0;
      fired       = 1'b0;
    end
    if (!rsp_valid_o && rsp_q.size() != 0) begin
      if (wait_cnt == 0) begin
        rsp_valid_o = 1'b1;
        rsp_o.rdata = rsp_q[0];
        wait_cnt    = $urandom % (MaxDelay + 1);
      end else begin
        wait_cnt--;
      end
    end
  end

endmodule

module tb_cc import cc_pkg::*;;

  localparam int Timeout = 200;

  logic clk_i, rst_ni;
  logic [`CC_ADDR_W-1:0] tcdm_base_i;
  logic acc_req_valid_i, acc_req_ready_o, acc_rsp_valid_o, acc_rsp_ready_i;
  acc_req_t acc_req_i, acc_req_o;
  acc_rsp_t acc_rsp_o;
  logic [`CC_NUM_ACC-1:0] acc_req_valid_o, acc_req_ready_i, acc_rsp_valid_i, acc_rsp_ready_o;
  acc_rsp_t [`CC_NUM_ACC-1:0] acc_rsp_i;
  logic data_req_valid_i, data_req_ready_o, data_rsp_valid_o, data_rsp_ready_i;
  data_req_t data_req_i, soc_req_o, tcdm_req_o;
  data_rsp_t data_rsp_o, soc_rsp_i, tcdm_rsp_i;
  logic soc_req_valid_o, soc_req_ready_i, soc_rsp_valid_i, soc_rsp_ready_o;
  logic tcdm_req_valid_o, tcdm_req_ready_i, tcdm_rsp_valid_i, tcdm_rsp_ready_o;

  // Scoreboard, offload by id and data in request order
  logic        acc_pend [32];
  logic [32:0] acc_exp [32];
  logic [31:0] acc_op [32];
  string       acc_nm [32];
  int          acc_open;
  logic [31:0] d_exp [64];
  string       d_nm [64];
  int          d_wr, d_rd;
  int          tests, errors;

  // Accelerator queue entries are {port, id, data}
  logic [38:0] acc_q [$];
  int          acc_wait [`CC_NUM_ACC];
  logic [`CC_NUM_ACC-1:0] acc_fire;

  cc_top i_dut (.*);

  mem_port_model #(.MaxDelay(1)) i_tcdm (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_valid_i(tcdm_req_valid_o),
    .req_ready_o(tcdm_req_ready_i), .req_i(tcdm_req_o), .rsp_valid_o(tcdm_rsp_valid_i),
    .rsp_ready_i(tcdm_rsp_ready_o), .rsp_o(tcdm_rsp_i)
  );

  // SoC answers slower
  mem_port_model #(.MaxDelay(8)) i_soc (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_valid_i(soc_req_valid_o),
    .req_ready_o(soc_req_ready_i), .req_i(soc_req_o), .rsp_valid_o(soc_rsp_valid_i),
    .rsp_ready_i(soc_rsp_ready_o), .rsp_o(soc_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic int find_acc_entry(input int k);
    for (int i = 0; i < acc_q.size(); i++) begin
      if (acc_q[i][38:37] == k) return i;
    end
    return -1;
  endfunction

  task automatic report_result(input string name, input logic [32:0] exp, input logic [32:0] act);
    tests++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end else begin
      $display("done %s", name);
    end
  endtask

  // Offload values are compared as {error, data}
  task automatic check_offload(input acc_rsp_t rsp);
    if (!acc_pend[rsp.id]) begin
      errors++;
      $display("offload response with id %0d has no open request", rsp.id);
    end else begin
      acc_pend[rsp.id] = 1'b0;
      acc_open--;
      report_result(acc_nm[rsp.id], acc_exp[rsp.id], {rsp.error, rsp.data});
    end
  endtask

  // Accelerator port k: data is arg plus k, in order per port
  always @(posedge clk_i) begin
    int idx;
    if (rst_ni) begin
      for (int k = 0; k < `CC_NUM_ACC; k++) begin
        if (acc_req_valid_o[k] && acc_req_o.target != k) begin
          errors++;
          $display("offload request for target %0d showed up at port %0d", acc_req_o.target, k);
        end
        if (acc_req_valid_o[k] && acc_req_ready_i[k]) begin
          if (acc_req_o.op !== acc_op[acc_req_o.id]) begin
            errors++;
            $display("mismatch %s expected op %h actual %h", acc_nm[acc_req_o.id],
                     acc_op[acc_req_o.id], acc_req_o.op);
          end
          acc_q.push_back({2'(k), acc_req_o.id, acc_req_o.arg + 32'(k)});
        end
        if (acc_rsp_valid_i[k] && acc_rsp_ready_o[k]) begin
          idx = find_acc_entry(k);
          acc_q.delete(idx);
          acc_fire[k] = 1'b1;
        end
      end
      if (acc_rsp_valid_o && acc_rsp_ready_i) check_offload(acc_rsp_o);
      if (data_rsp_valid_o && data_rsp_ready_i) begin
        if (d_rd == d_wr) begin
          errors++;
          $display("data response arrived with no request outstanding");
        end else begin
          report_result(d_nm[d_rd % 64], {1'b0, d_exp[d_rd % 64]}, {1'b0, data_rsp_o.rdata});
          d_rd++;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    int idx;
    for (int k = 0; k < `CC_NUM_ACC; k++) begin
      acc_req_ready_i[k] = ($urandom % 4) != 0;
      if (acc_fire[k]) begin
        acc_rsp_valid_i[k] = 1'b0;
        acc_fire[k]        = 1'b0;
      end
      idx = find_acc_entry(k);
      if (!acc_rsp_valid_i[k] && idx >= 0) begin
        if (acc_wait[k] == 0) begin
          acc_rsp_valid_i[k]    = 1'b1;
          acc_rsp_i[k].id    = acc_q[idx][36:32];
          acc_rsp_i[k].data  = acc_q[idx][31:0];
          acc_rsp_i[k].error = 1'b0;
          acc_wait[k]        = $urandom % 4;
        end else begin
          acc_wait[k]--;
        end
      end
    end
  end

  task automatic send_offload(input string name, input logic [31:0] id, tgt, op, arg, ed, ee);
    int t;
    acc_pend[id[4:0]] = 1'b1;
    acc_exp[id[4:0]]  = {ee[0], ed};
    acc_op[id[4:0]]   = op;
    acc_nm[id[4:0]]   = name;
    acc_open++;
    acc_req_valid_i  = 1'b1;
    acc_req_i.id     = id[4:0];
    acc_req_i.target = tgt[1:0];
    acc_req_i.op     = op;
    acc_req_i.arg    = arg;
    t = 0;
    @(posedge clk_i);
    while (!acc_req_ready_o && t < Timeout) begin
      @(posedge clk_i);
      t++;
    end
    if (!acc_req_ready_o) begin
      errors++;
      $display("offload request %s was never accepted", name);
    end
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
  endtask

  task automatic send_data(input string name, input logic [31:0] wr, addr, wdata, strb, ed, tc);
    int t;
    d_exp[d_wr % 64] = ed;
    d_nm[d_wr % 64]  = name;
    d_wr++;
    data_req_valid_i = 1'b1;
    data_req_i       = '{addr: addr, write: wr[0], wdata: wdata, strb: strb[3:0]};
    t = 0;
    @(posedge clk_i);
    while (!data_req_ready_o && t < Timeout) begin
      @(posedge clk_i);
      t++;
    end
    if (!data_req_ready_o) begin
      errors++;
      $display("data request %s was never accepted", name);
    end else if ({tcdm_req_valid_o, soc_req_valid_o} !== {tc[0], !tc[0]}) begin
      errors++;
      $display("mismatch %s expected port %b actual %b", name, {tc[0], !tc[0]},
               {tcdm_req_valid_o, soc_req_valid_o});
    end
    @(negedge clk_i);
    data_req_valid_i = 1'b0;
  endtask

  task automatic drain_outstanding();
    int t;
    t = 0;
    while ((acc_open != 0 || d_rd != d_wr) && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    if (acc_open != 0 || d_rd != d_wr) begin
      errors++;
      $display("timed out with %0d offload and %0d data responses missing", acc_open, d_wr - d_rd);
    end
  endtask

  initial begin
    int          fd;
    string       line, kind, name;
    logic [31:0] a, b, c, d, e, g;
    void'($urandom(32'h09b6_b2b0));
    rst_ni = 1'b0;
    tcdm_base_i = 32'h1000_0000;
    acc_req_valid_i = 1'b0;
    acc_req_i = '0;
    acc_rsp_ready_i = 1'b1;
    acc_req_ready_i = '0;
    acc_rsp_valid_i = '0;
    acc_rsp_i = '0;
    acc_fire = '0;
    data_req_valid_i = 1'b0;
    data_req_i = '0;
    data_rsp_ready_i = 1'b1;
    acc_open = 0;
    d_wr = 0;
    d_rd = 0;
    tests = 0;
    errors = 0;
    for (int i = 0; i < 32; i++) acc_pend[i] = 1'b0;
    for (int k = 0; k < `CC_NUM_ACC; k++) acc_wait[k] = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    fd = $fopen("verification/cc_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        kind = "";
        void'($fgets(line, fd));
        if ($sscanf(line, "%s", kind) == 1 && kind[0] != "#") begin
          if (kind == "offload" || kind == "data") begin
            void'($sscanf(line, "%s %s %h %h %h %h %h %h", kind, name, a, b, c, d, e, g));
            if (kind == "offload") send_offload(name, a, b, c, d, e, g);
            else send_data(name, a, b, c, d, e, g);
          end else if (kind == "hold") begin
            void'($sscanf(line, "%s %h", kind, a));
            if (a == 0) repeat (20) @(negedge clk_i);
            acc_rsp_ready_i  = (a == 0);
            data_rsp_ready_i = (a == 0);
          end else if (kind == "wait") begin
            drain_outstanding();
          end else begin
            errors++;
            $display("unknown stimulus kind %s", kind);
          end
        end
      end
      $fclose(fd);
    end
    drain_outstanding();

    $display("tests %0d errors %0d", tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
source/cc_pkg.sv
source/acc_if.sv
source/spill_reg.sv
source/offload_router.sv
source/data_router.sv
source/cc_top.sv
verification/tb_cc.sv

// ==== verification/cc_stimulus.txt ====
# offload: name id target op arg exp_data exp_error, data: name write addr wdata strb exp_rdata exp_tcdm
# hold 1 stops both response readies, hold 0 idles 20 cycles then releases, wait drains
offload acc_t0 01 0 00000013 00001000 00001000 0
offload acc_t1 02 1 00000013 00002000 00002001 0
offload acc_t2 03 2 00000013 00003000 00003002 0
wait
offload bad_tgt 04 3 00000000 12345678 00000000 1
wait
offload mix_a 05 0 00000001 0000aa00 0000aa00 0
offload mix_b 06 1 00000002 0000bb00 0000bb01 0
offload mix_c 07 2 00000003 0000cc00 0000cc02 0
offload mix_d 08 1 00000004 0000dd00 0000dd01 0
offload mix_e 09 0 00000005 0000ee00 0000ee00 0
wait
data tcdm_wr 1 10000040 cafef00d f 00000000 1
data tcdm_wr_b 1 10000040 11223344 5 00000000 1
data tcdm_rd 0 10000040 00000000 0 ca22f044 1
data soc_wr 1 20000080 0badbeef f 00000000 0
data near_wr 1 10001040 600dcafe 3 00000000 0
wait
data mix_soc 0 20000080 00000000 0 0badbeef 0
data mix_tcdm 0 10000040 00000000 0 ca22f044 1
data mix_near 0 10001040 00000000 0 b5a5cafe 0
data mix_tcdm2 0 10000040 00000000 0 ca22f044 1
wait
hold 1
offload hold_a 0a 0 00000000 00000100 00000100 0
offload hold_b 0b 2 00000000 00000200 00000202 0
offload hold_c 0c 1 00000000 00000300 00000301 0
data hold_tcdm 0 10000040 00000000 0 ca22f044 1
data hold_soc 0 20000080 00000000 0 0badbeef 0
hold 0
wait
